// ==== compile.f ====
+incdir+.
cpuIsaPkg.sv
cpuCtrlPkg.sv
ctrlIf.sv
timingSequencer.sv
instructionRegister.sv
controlDecoder.sv
dataPath.sv
cpuSystem.sv
cpuSystem_asserts.sv
tbCpuSystem.sv

// ==== Makefile ====
TOP = tbCpuSystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// ==== tbCpuSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbCpuSystem;
    import cpuCtrlPkg::*;

    localparam int ProgramLength = 6;
    localparam int TimeoutCycles = 60;     // 6 instructions of up to 7 cycles plus margin
    localparam logic [5:0] OpLdal = 6'h1E;
    localparam logic [5:0] OpSta  = 6'h20;
    localparam logic [5:0] OpNop  = 6'h09;

    logic       Clock = 1'b0;
    logic       Reset;
    logic [7:0] memRdData;
    logic [7:0] memAddress;
    logic [7:0] memWrData;
    logic       memSelect;
    logic       memWrite;
    tState_t    T;

    logic [7:0]  mem [256];
    logic [7:0]  loadData [4];     // Source bytes at 0x80..0x83
    logic [31:0] rngState = 32'd51;
    int          cycleCount = 0;

    cpuSystem i_cpuSystem (
        .Clock      (Clock),
        .Reset      (Reset),
        .memRdData  (memRdData),
        .memAddress (memAddress),
        .memWrData  (memWrData),
        .memSelect  (memSelect),
        .memWrite   (memWrite),
        .T          (T)
    );

    always #20 Clock = ~Clock;

    // ========================================================================
    // Memory model
    // ========================================================================
    assign memRdData = mem[memAddress];    // Same-cycle read

    always @(posedge Clock) begin
        if (memSelect && memWrite) begin
            mem[memAddress] <= memWrData;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Opcode | register select | address
    function automatic logic [15:0] encodeInstr(input logic [5:0] op, input logic [1:0] rsel,
                                                input logic [7:0] addr);
        return {op, rsel, addr};
    endfunction

    task automatic placeInstr(input logic [7:0] at, input logic [15:0] word);
        mem[at]         = word[7:0];     // Low byte fetched first
        mem[at + 8'd1]  = word[15:8];
    endtask

    task automatic loadMemory();
        logic [8:0] addr;
        for (addr = 9'd0; addr < 9'd256; addr++) begin
            rngState = xorshift(rngState);
            mem[addr[7:0]] = rngState[7:0] ^ addr[7:0];
        end
        placeInstr(8'h00, encodeInstr(OpLdal, 2'd0, 8'h80));  // LDAL R1,0x80
        placeInstr(8'h02, encodeInstr(OpSta,  2'd0, 8'h90));  // STA R1,0x90
        placeInstr(8'h04, encodeInstr(OpNop,  2'd0, 8'h00));
        placeInstr(8'h06, encodeInstr(OpSta,  2'd1, 8'hA0));  // STA R2,0xA0
        placeInstr(8'h08, encodeInstr(OpLdal, 2'd2, 8'h82));  // LDAL R3,0x82
        placeInstr(8'h0A, encodeInstr(OpSta,  2'd2, 8'hA2));  // STA R3,0xA2
        loadData[0] = mem[8'h80];
        loadData[1] = mem[8'h81];
        loadData[2] = mem[8'h82];
        loadData[3] = mem[8'h83];
    endtask

    task automatic checkByte(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
        assert (actual === expected) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Run limit and concurrent assertion watch
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        assert (cycleCount < TimeoutCycles) else begin
            $display("Timeout: program did not finish within %0d cycles", TimeoutCycles);
            $display("Simulation failed");
            $fatal(1);
        end
        assert (i_cpuSystem.u_asserts.failCount == 0) else begin
            $display("A concurrent assertion on the DUT failed");
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // ========================================================================
    // Stimulus and end-of-run checks
    // ========================================================================
    initial begin
        int startCount;
        Reset = 1'b1;
        loadMemory();
        repeat (2) @(posedge Clock);
        Reset <= 1'b0;
        startCount = 0;
        while (startCount < ProgramLength + 1) begin  // Wait for the 7th fetch
            @(negedge Clock);
            if (T == T0) begin
                startCount = startCount + 1;
            end
        end
        checkByte("mem[0x90]", mem[8'h90], loadData[0]);
        checkByte("mem[0x91]", mem[8'h91], loadData[1]);
        checkByte("mem[0xA0]", mem[8'hA0], 8'h00);     // R2 still at reset value
        checkByte("mem[0xA1]", mem[8'hA1], 8'h00);
        checkByte("mem[0xA2]", mem[8'hA2], loadData[2]);
        checkByte("mem[0xA3]", mem[8'hA3], loadData[3]);
        if (i_cpuSystem.u_asserts.failCount == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("A concurrent assertion on the DUT failed");
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== cpuSystem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuSystem_asserts (
    input logic                Clock,
    input logic                Reset,
    input cpuCtrlPkg::tState_t T,
    input logic                memSelect,
    input logic                memWrite,
    input cpuIsaPkg::memAddr_t memAddress,
    input cpuIsaPkg::opcode_t  opcode
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    int unsigned failCount = 0;     // Polled by the testbench

    // ========================================================================
    // Reset and sequencer
    // ========================================================================
    resetState: assert property (@(posedge Clock)
        $fell(Reset) |-> (T == T0) && !memWrite)
        else begin
            failCount = failCount + 1;
            $error("T not T0 or memWrite high right after reset");
        end

    stateOneHot: assert property (@(posedge Clock) disable iff (Reset) $onehot(T))
        else begin
            failCount = failCount + 1;
            $error("Timing state is not one-hot");
        end

    // ========================================================================
    // Fetch
    // ========================================================================
    fetchRead: assert property (@(posedge Clock) disable iff (Reset)
        (T == T0 || T == T1) |-> memSelect && !memWrite)
        else begin
            failCount = failCount + 1;
            $error("Fetch cycle without a memory read");
        end

    fetchNextByte: assert property (@(posedge Clock) disable iff (Reset)
        (T == T0) |=> (T == T1) && (memAddress == $past(memAddress) + 8'd1))
        else begin
            failCount = failCount + 1;
            $error("Second fetch byte not at the next address");
        end

    // Store writes two consecutive bytes, then the next fetch
    storePair: assert property (@(posedge Clock) disable iff (Reset)
        (T == T4 && memWrite) |=>
            (T == T5 && memWrite && memAddress == $past(memAddress) + 8'd1)
            ##1 (T == T0))
        else begin
            failCount = failCount + 1;
            $error("Store did not write two consecutive bytes and restart");
        end

    noOpRestart: assert property (@(posedge Clock) disable iff (Reset)
        (T == T3 && opcode != LDAL && opcode != STA) |-> !memWrite ##1 (T == T0))
        else begin
            failCount = failCount + 1;
            $error("No-op did not restart after T3");
        end

endmodule

bind cpuSystem cpuSystem_asserts u_asserts (
    .Clock      (Clock),
    .Reset      (Reset),
    .T          (T),
    .memSelect  (memSelect),
    .memWrite   (memWrite),
    .memAddress (memAddress),
    .opcode     (opcode)
);

`default_nettype wire

// ==== cpuSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuSystem (
    input  logic                Clock,
    input  logic                Reset,
    input  cpuIsaPkg::memByte_t memRdData,
    output cpuIsaPkg::memAddr_t memAddress,
    output cpuIsaPkg::memByte_t memWrData,
    output logic                memSelect,
    output logic                memWrite,
    output cpuCtrlPkg::tState_t T
);
    import cpuIsaPkg::*;

    logic     restart;
    opcode_t  opcode;
    regSel_t  regSel;
    memAddr_t address;

    ctrlIf ctrlBus ();      // Decoder to datapath strobes

    timingSequencer i_timingSequencer (
        .Clock   (Clock),
        .Reset   (Reset),
        .restart (restart),
        .state   (T)
    );

    instructionRegister i_instructionRegister (
        .Clock     (Clock),
        .Reset     (Reset),
        .state     (T),
        .memRdData (memRdData),
        .opcode    (opcode),
        .regSel    (regSel),
        .address   (address)
    );

    controlDecoder i_controlDecoder (
        .state     (T),
        .opcode    (opcode),
        .regSel    (regSel),
        .ctrl      (ctrlBus.decoder),
        .memSelect (memSelect),
        .memWrite  (memWrite),
        .restart   (restart)
    );

    dataPath i_dataPath (
        .Clock      (Clock),
        .Reset      (Reset),
        .ctrl       (ctrlBus.datapath),
        .memRdData  (memRdData),
        .address    (address),
        .memAddress (memAddress),
        .memWrData  (memWrData)
    );

endmodule

`default_nettype wire

// ==== dataPath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module dataPath (
    input  logic                Clock,
    input  logic                Reset,
    ctrlIf.datapath             ctrl,
    input  cpuIsaPkg::memByte_t memRdData,
    input  cpuIsaPkg::memAddr_t address,
    output cpuIsaPkg::memAddr_t memAddress,
    output cpuIsaPkg::memByte_t memWrData
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    localparam int RegCount = $bits(regEnable_t);

    memAddr_t  pc;
    memAddr_t  ar;
    dataWord_t dr;
    dataWord_t regFile [RegCount];  // R1 to R4
    dataWord_t readWord;

    // ========================================================================
    // Address registers
    // ========================================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= '0;
        end else if (ctrl.pcInc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            ar <= '0;
        end else if (ctrl.arLoad) begin
            ar <= address;  // Immediate from IR
        end else if (ctrl.arInc) begin
            ar <= ar + 1'b1;
        end
    end

    // ========================================================================
    // Data register and register file
    // ========================================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dr <= '0;
        end else if (ctrl.drShift) begin
            // New byte enters at the top
            dr <= {memRdData, dr[`CPU_DATA_WIDTH-1:`CPU_BYTE_WIDTH]};
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < RegCount; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RegCount; i++) begin
                if (ctrl.rfWrite[i]) begin
                    regFile[i] <= dr;
                end
            end
        end
    end

    // Memory side
    assign memAddress = (ctrl.addrSrc == ADDR_AR) ? ar : pc;
    assign readWord   = regFile[ctrl.readSel];
    assign memWrData  = ctrl.byteHigh ? readWord[`CPU_DATA_WIDTH-1:`CPU_BYTE_WIDTH]
                                      : readWord[`CPU_BYTE_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
    input  cpuCtrlPkg::tState_t state,
    input  cpuIsaPkg::opcode_t  opcode,
    input  cpuIsaPkg::regSel_t  regSel,
    ctrlIf.decoder              ctrl,
    output logic                memSelect,
    output logic                memWrite,
    output logic                restart
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    always_comb begin
        ctrl.pcInc    = 1'b0;
        ctrl.arLoad   = 1'b0;
        ctrl.arInc    = 1'b0;
        ctrl.addrSrc  = ADDR_PC;
        ctrl.drShift  = 1'b0;
        ctrl.rfWrite  = '0;
        ctrl.readSel  = '0;
        ctrl.byteHigh = 1'b0;
        memSelect     = 1'b0;
        memWrite      = 1'b0;
        restart       = 1'b0;

        case (state)
            // ================================================================
            // Fetch and decode
            // ================================================================
            T0, T1: begin
                memSelect   = 1'b1;     // Read instruction byte at PC
                ctrl.pcInc  = 1'b1;
            end
            T2: begin
                // IR complete, fields settle for T3
            end

            // ================================================================
            // Execute
            // ================================================================
            T3: begin
                case (opcode)
                    LDAL, STA: ctrl.arLoad = 1'b1;
                    default:   restart     = 1'b1;  // No-op ends here
                endcase
            end
            T4: begin
                case (opcode)
                    LDAL: begin
                        ctrl.addrSrc = ADDR_AR;
                        memSelect    = 1'b1;
                        ctrl.drShift = 1'b1;    // Low byte into DR
                        ctrl.arInc   = 1'b1;
                    end
                    STA: begin
                        ctrl.addrSrc  = ADDR_AR;
                        ctrl.readSel  = regSel;
                        ctrl.byteHigh = 1'b0;   // Little-endian, low byte first
                        memSelect     = 1'b1;
                        memWrite      = 1'b1;
                        ctrl.arInc    = 1'b1;
                    end
                    default: restart = 1'b1;
                endcase
            end
            T5: begin
                case (opcode)
                    LDAL: begin
                        ctrl.addrSrc = ADDR_AR;
                        memSelect    = 1'b1;
                        ctrl.drShift = 1'b1;    // High byte, low one moves down
                    end
                    STA: begin
                        ctrl.addrSrc  = ADDR_AR;
                        ctrl.readSel  = regSel;
                        ctrl.byteHigh = 1'b1;
                        memSelect     = 1'b1;
                        memWrite      = 1'b1;
                        restart       = 1'b1;
                    end
                    default: restart = 1'b1;
                endcase
            end
            T6: begin
                if (opcode == LDAL) begin
                    ctrl.rfWrite = regEnable_t'(4'b0001 << regSel);
                end
                restart = 1'b1;
            end
            default: restart = 1'b1;    // T7 to T11 unused
        endcase
    end

endmodule

`default_nettype wire

// ==== instructionRegister.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module instructionRegister (
    input  logic                Clock,
    input  logic                Reset,
    input  cpuCtrlPkg::tState_t state,
    input  cpuIsaPkg::memByte_t memRdData,
    output cpuIsaPkg::opcode_t  opcode,
    output cpuIsaPkg::regSel_t  regSel,
    output cpuIsaPkg::memAddr_t address
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    instrWord_t instr;

    // Low byte comes first from memory
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            instr <= '0;    // Decodes as a no-op
        end else if (state == T0) begin
            instr[`CPU_BYTE_WIDTH-1:0] <= memRdData;
        end else if (state == T1) begin
            instr[`CPU_DATA_WIDTH-1:`CPU_BYTE_WIDTH] <= memRdData;
        end
    end

    // Fixed fields  opcode | regSel | address
    assign opcode  = opcode_t'(instr[`CPU_DATA_WIDTH-1 -: `CPU_OPCODE_WIDTH]);
    assign regSel  = instr[`CPU_ADDR_WIDTH+1:`CPU_ADDR_WIDTH];
    assign address = instr[`CPU_ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== timingSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module timingSequencer (
    input  logic                Clock,
    input  logic                Reset,
    input  logic                restart,
    output cpuCtrlPkg::tState_t state
);
    import cpuCtrlPkg::*;

    // ========================================================================
    // One-hot ring, T11 would wrap to T0 if it were ever reached
    // ========================================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state <= T0;
        end else if (restart) begin
            state <= T0;    // Last state of the instruction
        end else begin
            state <= tState_t'({state[`CPU_STATE_COUNT-2:0],
                                state[`CPU_STATE_COUNT-1]});
        end
    end

endmodule

`default_nettype wire

// ==== ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    logic       pcInc;      // PC <- PC + 1
    logic       arLoad;     // AR <- instruction address field
    logic       arInc;      // AR <- AR + 1
    addrSrc_t   addrSrc;    // Drives memAddress
    logic       drShift;    // DR <- {memRdData, DR[15:8]}
    regEnable_t rfWrite;    // Selected register <- DR
    regSel_t    readSel;    // Store source register
    logic       byteHigh;   // Upper half of the store source

    modport decoder (
        output pcInc, arLoad, arInc, addrSrc, drShift,
        output rfWrite, readSel, byteHigh
    );

    modport datapath (
        input pcInc, arLoad, arInc, addrSrc, drShift,
        input rfWrite, readSel, byteHigh
    );

endinterface

`default_nettype wire

// ==== cpuCtrlPkg.sv ====
`default_nettype none

`include "cpu_macros.svh"

package cpuCtrlPkg;

    // One-hot timing states
    typedef enum logic [`CPU_STATE_COUNT-1:0] {
        T0  = 12'h001,
        T1  = 12'h002,
        T2  = 12'h004,
        T3  = 12'h008,
        T4  = 12'h010,
        T5  = 12'h020,
        T6  = 12'h040,
        T7  = 12'h080,
        T8  = 12'h100,
        T9  = 12'h200,
        T10 = 12'h400,
        T11 = 12'h800
    } tState_t;

    // Source of the memory address
    typedef enum logic {
        ADDR_PC = 1'b0,
        ADDR_AR = 1'b1
    } addrSrc_t;

    typedef logic [3:0] regEnable_t;   // Bit 0 is R1

endpackage

`default_nettype wire

// ==== cpuIsaPkg.sv ====
`default_nettype none

`include "cpu_macros.svh"

package cpuIsaPkg;

    typedef logic [`CPU_DATA_WIDTH-1:0]  dataWord_t;    // Register contents
    typedef logic [`CPU_ADDR_WIDTH-1:0]  memAddr_t;     // Also the instruction address field
    typedef logic [`CPU_BYTE_WIDTH-1:0]  memByte_t;
    typedef logic [`CPU_DATA_WIDTH-1:0]  instrWord_t;   // Two fetched bytes

    // Only the two implemented opcodes are named, all others act as no-ops
    typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
        LDAL = 6'h1E,   // Rx <- mem[addr+1], mem[addr]
        STA  = 6'h20    // mem[addr], mem[addr+1] <- Rx
    } opcode_t;

    typedef logic [1:0] regSel_t;   // 0 to 3 select R1 to R4

endpackage

`default_nettype wire

// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath widths
`define CPU_DATA_WIDTH   16   // General registers and DR
`define CPU_ADDR_WIDTH   8    // Byte address into memory
`define CPU_BYTE_WIDTH   8    // Memory data bus

// Instruction and sequencer sizes
`define CPU_OPCODE_WIDTH 6    // Top bits of the instruction word
`define CPU_STATE_COUNT  12   // T0 to T11

`endif
